// File: verilog/streamer_pkg.sv
// Streamer package with bus widths, handshake structs and load selection codes
`default_nettype none

package streamer_pkg;

  localparam int unsigned DW               = 32;
  localparam int unsigned AW               = 16;
  localparam int unsigned META_W           = 32;
  localparam int unsigned FIELD_W          = 8;
  localparam int unsigned FIELDS_PER_CHUNK = META_W / FIELD_W;
  localparam int unsigned Z_ITEM_W         = 16;
  localparam int unsigned LEN_W            = 8;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [AW-1:0]     addr;
    logic [DW-1:0]     wdata;
    logic [DW/8-1:0]   be;
  } mem_req_t;

  // rvalid comes one cycle after the read grant
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DW-1:0]     rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [AW-1:0]     addr;
    logic [LEN_W-1:0]  len;
  } burst_cmd_t;

  typedef struct packed {
    logic              ready_start;
    logic              done;
  } burst_flags_t;

  typedef struct packed {
    logic              valid;
    logic              ready;
    logic [DW-1:0]     data;
  } stream_t;

  // Block length doubles as the burst length
  typedef struct packed {
    logic [AW-1:0]     base;
    logic [LEN_W-1:0]  len;
  } sched_params_t;

  typedef struct packed {
    logic [AW-1:0]     meta_base;
    sched_params_t     x;
    sched_params_t     y;
    logic [AW-1:0]     z_base;
  } run_params_t;

  typedef struct packed {
    logic              working;
    logic              done;
  } run_ctrl_t;

  typedef enum logic [1:0] {
    SEL_META,
    SEL_X,
    SEL_Y
  } load_sel_e;

endpackage

`default_nettype wire

// File: verilog/mem_port_arbiter.sv
// Memory port arbiter sharing one port between the load and store channels
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter import streamer_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  mem_req_t ld_req_i,
  output mem_rsp_t ld_rsp_o,
  input  mem_req_t st_req_i,
  output mem_rsp_t st_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);

  logic ld_gnt;
  logic st_gnt;
  logic ld_rd_q;
  logic st_rd_q;

  // Fixed priority, store first
  assign st_gnt    = mem_rsp_i.gnt & st_req_i.req;
  assign ld_gnt    = mem_rsp_i.gnt & ld_req_i.req & ~st_req_i.req;
  assign mem_req_o = st_req_i.req ? st_req_i : ld_req_i;

  always_comb begin
    ld_rsp_o.gnt    = ld_gnt;
    ld_rsp_o.rvalid = mem_rsp_i.rvalid & ld_rd_q;
    ld_rsp_o.rdata  = mem_rsp_i.rdata;
    st_rsp_o.gnt    = st_gnt;
    st_rsp_o.rvalid = mem_rsp_i.rvalid & st_rd_q;
    st_rsp_o.rdata  = mem_rsp_i.rdata;
  end

  // Owner of the read in flight, fixed latency of one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_rd_q <= 1'b0;
      st_rd_q <= 1'b0;
    end else if (clear_i) begin
      ld_rd_q <= 1'b0;
      st_rd_q <= 1'b0;
    end else begin
      ld_rd_q <= ld_gnt & ~ld_req_i.we;
      st_rd_q <= st_gnt & ~st_req_i.we;
    end
  end

  a_rvalid_after_read: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_i.rvalid |-> $past(mem_req_o.req && !mem_req_o.we && mem_rsp_i.gnt)
  ) else $error("mem_port_arbiter: rvalid without a granted read");

endmodule

`default_nettype wire

// File: verilog/burst_source.sv
// Burst source issuing linear word reads and streaming out the returned data
`timescale 1ns/1ps
`default_nettype none

module burst_source import streamer_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  burst_cmd_t    cmd_i,
  input  logic          req_start_i,
  output burst_flags_t  flags_o,
  output mem_req_t      mem_req_o,
  input  mem_rsp_t      mem_rsp_i,
  output logic          valid_o,
  output logic [DW-1:0] data_o,
  input  logic          ready_i
);

  logic             busy_q;
  logic [AW-1:0]    addr_q;
  logic [LEN_W-1:0] left_q;
  logic             pending_q;
  logic             out_valid_q;
  logic [DW-1:0]    out_data_q;
  logic             done_q;
  logic             issue;
  logic             drained;

  // One read in flight at most, and only into an empty output register
  assign issue   = busy_q & (left_q != '0) & ~pending_q & ~out_valid_q;
  assign drained = busy_q & (left_q == '0) & ~pending_q & ~out_valid_q;

  always_comb begin
    mem_req_o      = '0;
    mem_req_o.req  = issue;
    mem_req_o.addr = addr_q;
    mem_req_o.be   = '1;
  end

  assign valid_o             = out_valid_q;
  assign data_o              = out_data_q;
  assign flags_o.ready_start = ~busy_q;
  assign flags_o.done        = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      addr_q      <= '0;
      left_q      <= '0;
      pending_q   <= 1'b0;
      out_valid_q <= 1'b0;
      done_q      <= 1'b0;
    end else if (clear_i) begin
      busy_q      <= 1'b0;
      addr_q      <= '0;
      left_q      <= '0;
      pending_q   <= 1'b0;
      out_valid_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      // Done pulses once the last word has left the output register
      done_q <= drained;
      if (req_start_i && !busy_q) begin
        busy_q <= 1'b1;
        addr_q <= cmd_i.addr;
        left_q <= cmd_i.len;
      end else if (drained) begin
        busy_q <= 1'b0;
      end
      if (issue && mem_rsp_i.gnt) begin
        addr_q    <= addr_q + AW'(1);
        left_q    <= left_q - LEN_W'(1);
        pending_q <= 1'b1;
      end
      if (mem_rsp_i.rvalid) begin
        pending_q   <= 1'b0;
        out_valid_q <= 1'b1;
      end else if (out_valid_q && ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.rvalid) begin
      out_data_q <= mem_rsp_i.rdata;
    end
  end

  a_rvalid_room: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_i.rvalid |-> pending_q && !out_valid_q
  ) else $error("burst_source: rvalid while the output register is full");

endmodule

`default_nettype wire

// File: verilog/block_scheduler.sv
// Block scheduler stepping through metadata fields to build burst commands
`timescale 1ns/1ps
`default_nettype none

module block_scheduler import streamer_pkg::*; #(
  parameter int unsigned FIELDS_PER_CHUNK = streamer_pkg::FIELDS_PER_CHUNK
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic [META_W-1:0] chunk_i,
  input  logic              meta_loaded_i,
  input  logic              proceed_i,
  input  sched_params_t     params_i,
  output logic              meta_used_o,
  output burst_cmd_t        cmd_o
);

  localparam int unsigned IDX_W = (FIELDS_PER_CHUNK > 1) ? $clog2(FIELDS_PER_CHUNK) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FIELDS_PER_CHUNK - 1);

  logic [IDX_W-1:0]   idx_q;
  logic               meta_used_q;
  logic [FIELD_W-1:0] field;

  assign field = chunk_i[idx_q*FIELD_W +: FIELD_W];

  // Block f starts f block lengths above the operand base
  assign cmd_o.addr  = params_i.base + AW'(field) * AW'(params_i.len);
  assign cmd_o.len   = params_i.len;
  assign meta_used_o = meta_used_q;

  // Chunk counts as used out of reset so that metadata is fetched first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q       <= '0;
      meta_used_q <= 1'b1;
    end else if (clear_i) begin
      idx_q       <= '0;
      meta_used_q <= 1'b1;
    end else if (meta_loaded_i) begin
      idx_q       <= '0;
      meta_used_q <= 1'b0;
    end else if (proceed_i) begin
      if (idx_q == LAST_IDX) begin
        idx_q       <= '0;
        meta_used_q <= 1'b1;
      end else begin
        idx_q <= idx_q + IDX_W'(1);
      end
    end
  end

  a_no_proceed_when_used: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    proceed_i && !meta_loaded_i |-> !meta_used_q
  ) else $error("block_scheduler: proceed on a used chunk");

endmodule

`default_nettype wire

// File: verilog/load_controller.sv
// Load controller running the load FSM, metadata buffer and output demux
`timescale 1ns/1ps
`default_nettype none

module load_controller import streamer_pkg::*; #(
  parameter int unsigned FIELDS_PER_CHUNK = streamer_pkg::FIELDS_PER_CHUNK
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  run_ctrl_t         run_ctrl_i,
  input  run_params_t       run_params_i,
  output mem_req_t          ld_req_o,
  input  mem_rsp_t          ld_rsp_i,
  output logic              x_valid_o,
  output logic [DW-1:0]     x_data_o,
  input  logic              x_ready_i,
  output logic              y_valid_o,
  output logic [DW-1:0]     y_data_o,
  input  logic              y_ready_i,
  output logic [META_W-1:0] metadata_o
);

  typedef enum logic [2:0] {
    SRC_INACTIVE,
    SRC_IDLE,
    LOADING_META,
    LOADING_X,
    LOADING_Y
  } load_state_e;

  load_state_e       state_q, state_d;
  run_params_t       params_q;
  logic [AW-1:0]     meta_cnt_q;
  logic [META_W-1:0] meta_q;
  burst_cmd_t        cmd_q, cmd_d;
  burst_cmd_t        x_cmd, y_cmd;
  logic              req_start_q, req_start_d;
  burst_flags_t      src_flags;
  logic              src_valid;
  logic              src_ready;
  logic [DW-1:0]     src_data;
  load_sel_e         sel;
  logic              run_start;
  logic              sched_clear;
  logic              x_used, y_used;
  logic              x_proceed, y_proceed;
  logic              meta_loaded;
  logic              meta_valid;
  logic              need_meta, load_x, load_y;

  assign run_start   = (state_q == SRC_INACTIVE) & run_ctrl_i.working;
  // Schedulers restart with every run
  assign sched_clear = clear_i | run_start;
  assign need_meta   = x_used & y_used;
  assign load_x      = x_ready_i & ~x_used;
  assign load_y      = y_ready_i & ~y_used;

  always_comb begin
    state_d     = state_q;
    cmd_d       = cmd_q;
    req_start_d = 1'b0;
    x_proceed   = 1'b0;
    y_proceed   = 1'b0;
    meta_loaded = 1'b0;
    case (state_q)
      SRC_INACTIVE: begin
        if (run_ctrl_i.working) begin
          state_d = SRC_IDLE;
        end
      end
      SRC_IDLE: begin
        if (run_ctrl_i.done) begin
          state_d = SRC_INACTIVE;
        end else if (src_flags.ready_start) begin
          req_start_d = need_meta | load_x | load_y;
          // Metadata first, then X, then Y
          if (need_meta) begin
            state_d    = LOADING_META;
            cmd_d.addr = params_q.meta_base + meta_cnt_q;
            cmd_d.len  = LEN_W'(1);
          end else if (load_x) begin
            state_d = LOADING_X;
            cmd_d   = x_cmd;
          end else if (load_y) begin
            state_d = LOADING_Y;
            cmd_d   = y_cmd;
          end
        end
      end
      LOADING_META: begin
        if (src_flags.done) begin
          state_d     = SRC_IDLE;
          meta_loaded = 1'b1;
          x_proceed   = 1'b1;
          y_proceed   = 1'b1;
        end
      end
      LOADING_X: begin
        if (src_flags.done) begin
          state_d   = SRC_IDLE;
          x_proceed = 1'b1;
        end
      end
      LOADING_Y: begin
        if (src_flags.done) begin
          state_d   = SRC_IDLE;
          y_proceed = 1'b1;
        end
      end
      default: state_d = SRC_IDLE;
    endcase
  end

  // Demux select follows the burst being loaded
  always_comb begin
    case (state_q)
      LOADING_X: sel = SEL_X;
      LOADING_Y: sel = SEL_Y;
      default:   sel = SEL_META;
    endcase
    case (sel)
      SEL_X:   src_ready = x_ready_i;
      SEL_Y:   src_ready = y_ready_i;
      default: src_ready = 1'b1;
    endcase
  end

  assign meta_valid = src_valid & (sel == SEL_META);
  assign x_valid_o  = src_valid & (sel == SEL_X);
  assign y_valid_o  = src_valid & (sel == SEL_Y);
  assign x_data_o   = src_data;
  assign y_data_o   = src_data;
  assign metadata_o = meta_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= SRC_INACTIVE;
      params_q    <= '0;
      meta_cnt_q  <= '0;
      meta_q      <= '0;
      req_start_q <= 1'b0;
    end else if (clear_i) begin
      state_q     <= SRC_INACTIVE;
      params_q    <= '0;
      meta_cnt_q  <= '0;
      meta_q      <= '0;
      req_start_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      req_start_q <= req_start_d;
      if (run_start) begin
        params_q   <= run_params_i;
        meta_cnt_q <= '0;
      end else if (meta_loaded) begin
        meta_cnt_q <= meta_cnt_q + AW'(1);
      end
      if (meta_valid) begin
        meta_q <= src_data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    cmd_q <= cmd_d;
  end

  burst_source u_source (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .cmd_i       ( cmd_q       ),
    .req_start_i ( req_start_q ),
    .flags_o     ( src_flags   ),
    .mem_req_o   ( ld_req_o    ),
    .mem_rsp_i   ( ld_rsp_i    ),
    .valid_o     ( src_valid   ),
    .data_o      ( src_data    ),
    .ready_i     ( src_ready   )
  );

  block_scheduler #(
    .FIELDS_PER_CHUNK ( FIELDS_PER_CHUNK )
  ) x_sched (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( sched_clear ),
    .chunk_i       ( meta_q      ),
    .meta_loaded_i ( meta_loaded ),
    .proceed_i     ( x_proceed   ),
    .params_i      ( params_q.x  ),
    .meta_used_o   ( x_used      ),
    .cmd_o         ( x_cmd       )
  );

  block_scheduler #(
    .FIELDS_PER_CHUNK ( FIELDS_PER_CHUNK )
  ) y_sched (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( sched_clear ),
    .chunk_i       ( meta_q      ),
    .meta_loaded_i ( meta_loaded ),
    .proceed_i     ( y_proceed   ),
    .params_i      ( params_q.y  ),
    .meta_used_o   ( y_used      ),
    .cmd_o         ( y_cmd       )
  );

  // Source data only flows while exactly one burst destination is selected
  a_one_dest: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    src_valid |-> (state_q inside {LOADING_META, LOADING_X, LOADING_Y})
  ) else $error("load_controller: source data with no load destination selected");

endmodule

`default_nettype wire

// File: verilog/z_packer.sv
// Z packer collecting engine result items into full memory words
`timescale 1ns/1ps
`default_nettype none

module z_packer import streamer_pkg::*; #(
  parameter int unsigned ITEMS_PER_WORD = DW / Z_ITEM_W
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                z_valid_i,
  input  logic [Z_ITEM_W-1:0] z_data_i,
  output logic                z_ready_o,
  output logic                word_valid_o,
  output logic [DW-1:0]       word_data_o,
  input  logic                word_ready_i
);

  localparam int unsigned CNT_W = (ITEMS_PER_WORD > 1) ? $clog2(ITEMS_PER_WORD) : 1;
  localparam logic [CNT_W-1:0] LAST_ITEM = CNT_W'(ITEMS_PER_WORD - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             full_q;
  logic [DW-1:0]    word_q;
  logic             take;

  // Engine stalls while a full word waits for the store
  assign z_ready_o    = ~full_q;
  assign take         = z_valid_i & ~full_q;
  assign word_valid_o = full_q;
  assign word_data_o  = word_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else if (clear_i) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else if (take) begin
      cnt_q  <= (cnt_q == LAST_ITEM) ? '0 : cnt_q + CNT_W'(1);
      full_q <= (cnt_q == LAST_ITEM);
    end else if (full_q && word_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // First item lands in the low slice
  always_ff @(posedge clk_i) begin
    if (take) begin
      word_q[cnt_q*Z_ITEM_W +: Z_ITEM_W] <= z_data_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/z_store_engine.sv
// Z store engine writing packed result words at consecutive addresses
`timescale 1ns/1ps
`default_nettype none

module z_store_engine import streamer_pkg::*; #(
  parameter int unsigned ITEMS_PER_WORD = DW / Z_ITEM_W
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  run_ctrl_t           run_ctrl_i,
  input  logic [AW-1:0]       z_base_i,
  input  logic                z_valid_i,
  input  logic [Z_ITEM_W-1:0] z_data_i,
  output logic                z_ready_o,
  output mem_req_t            st_req_o,
  input  mem_rsp_t            st_rsp_i
);

  typedef enum logic [1:0] {
    SINK_INACTIVE,
    SINK_IDLE,
    STORING_Z
  } store_state_e;

  store_state_e  state_q, state_d;
  logic [AW-1:0] base_q;
  logic [AW-1:0] cnt_q;
  logic          word_valid;
  logic [DW-1:0] word_data;
  logic          word_ready;
  logic          storing;

  assign storing    = (state_q == STORING_Z);
  assign word_ready = storing & st_rsp_i.gnt;

  always_comb begin
    st_req_o       = '0;
    st_req_o.req   = storing;
    st_req_o.we    = 1'b1;
    st_req_o.addr  = base_q + cnt_q;
    st_req_o.wdata = word_data;
    st_req_o.be    = '1;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      SINK_INACTIVE: begin
        if (run_ctrl_i.working) begin
          state_d = SINK_IDLE;
        end
      end
      SINK_IDLE: begin
        if (run_ctrl_i.done) begin
          state_d = SINK_INACTIVE;
        end else if (word_valid) begin
          state_d = STORING_Z;
        end
      end
      STORING_Z: begin
        // Request holds until the grant
        if (st_rsp_i.gnt) begin
          state_d = SINK_IDLE;
        end
      end
      default: state_d = SINK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SINK_INACTIVE;
      base_q  <= '0;
      cnt_q   <= '0;
    end else if (clear_i) begin
      state_q <= SINK_INACTIVE;
      base_q  <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == SINK_INACTIVE && run_ctrl_i.working) begin
        base_q <= z_base_i;
        cnt_q  <= '0;
      end else if (word_ready) begin
        cnt_q <= cnt_q + AW'(1);
      end
    end
  end

  z_packer #(
    .ITEMS_PER_WORD ( ITEMS_PER_WORD )
  ) u_packer (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .z_valid_i    ( z_valid_i  ),
    .z_data_i     ( z_data_i   ),
    .z_ready_o    ( z_ready_o  ),
    .word_valid_o ( word_valid ),
    .word_data_o  ( word_data  ),
    .word_ready_i ( word_ready )
  );

endmodule

`default_nettype wire

// File: verilog/sparse_streamer.sv
// Sparse streamer top level joining the load, store and memory port blocks
`timescale 1ns/1ps
`default_nettype none

module sparse_streamer import streamer_pkg::*; #(
  parameter int unsigned FIELDS_PER_CHUNK = streamer_pkg::FIELDS_PER_CHUNK,
  parameter int unsigned ITEMS_PER_WORD   = DW / Z_ITEM_W
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  run_ctrl_t           run_ctrl_i,
  input  run_params_t         run_params_i,
  output logic                x_valid_o,
  output logic [DW-1:0]       x_data_o,
  input  logic                x_ready_i,
  output logic                y_valid_o,
  output logic [DW-1:0]       y_data_o,
  input  logic                y_ready_i,
  input  logic                z_valid_i,
  input  logic [Z_ITEM_W-1:0] z_data_i,
  output logic                z_ready_o,
  output mem_req_t            mem_req_o,
  input  mem_rsp_t            mem_rsp_i,
  output logic [META_W-1:0]   metadata_o
);

  mem_req_t ld_req;
  mem_rsp_t ld_rsp;
  mem_req_t st_req;
  mem_rsp_t st_rsp;

  load_controller #(
    .FIELDS_PER_CHUNK ( FIELDS_PER_CHUNK )
  ) u_load (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .run_ctrl_i   ( run_ctrl_i   ),
    .run_params_i ( run_params_i ),
    .ld_req_o     ( ld_req       ),
    .ld_rsp_i     ( ld_rsp       ),
    .x_valid_o    ( x_valid_o    ),
    .x_data_o     ( x_data_o     ),
    .x_ready_i    ( x_ready_i    ),
    .y_valid_o    ( y_valid_o    ),
    .y_data_o     ( y_data_o     ),
    .y_ready_i    ( y_ready_i    ),
    .metadata_o   ( metadata_o   )
  );

  z_store_engine #(
    .ITEMS_PER_WORD ( ITEMS_PER_WORD )
  ) u_store (
    .clk_i      ( clk_i               ),
    .rst_ni     ( rst_ni              ),
    .clear_i    ( clear_i             ),
    .run_ctrl_i ( run_ctrl_i          ),
    .z_base_i   ( run_params_i.z_base ),
    .z_valid_i  ( z_valid_i           ),
    .z_data_i   ( z_data_i            ),
    .z_ready_o  ( z_ready_o           ),
    .st_req_o   ( st_req              ),
    .st_rsp_i   ( st_rsp              )
  );

  mem_port_arbiter u_arbiter (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .clear_i   ( clear_i   ),
    .ld_req_i  ( ld_req    ),
    .ld_rsp_o  ( ld_rsp    ),
    .st_req_i  ( st_req    ),
    .st_rsp_o  ( st_rsp    ),
    .mem_req_o ( mem_req_o ),
    .mem_rsp_i ( mem_rsp_i )
  );

endmodule

`default_nettype wire

// File: tests/mem_model.sv
// Behavioral word memory with random grant stalls and one-cycle read latency
`timescale 1ns/1ps
`default_nettype none

module mem_model import streamer_pkg::*; #(
  parameter logic [31:0] SEED = 32'hc3432291
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o
);

  logic [DW-1:0] mem_q [2**AW];
  logic          gnt_en_q;
  logic          rvalid_q;
  logic [DW-1:0] rdata_q;
  integer        seed;

  // Every word gets its own random value
  initial begin
    seed = SEED;
    for (int a = 0; a < 2**AW; a++) begin
      mem_q[a[AW-1:0]] = $random(seed);
    end
  end

  assign mem_rsp_o.gnt    = mem_req_i.req & gnt_en_q;
  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.rdata  = rdata_q;

  // Grant is withheld in about one cycle out of four
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_en_q <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      gnt_en_q <= (($random(seed) % 4) != 0);
      rvalid_q <= mem_rsp_o.gnt & ~mem_req_i.we;
      if (mem_rsp_o.gnt && !mem_req_i.we) begin
        rdata_q <= mem_q[mem_req_i.addr];
      end
    end
  end

  // One request per cycle, so a write never meets a read of the same cycle
  always @(posedge clk_i) begin
    if (mem_rsp_o.gnt && mem_req_i.we) begin
      for (int b = 0; b < DW / 8; b++) begin
        if (mem_req_i.be[b]) begin
          mem_q[mem_req_i.addr][b*8 +: 8] = mem_req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_sparse_streamer.sv
// Testbench for the sparse streamer driving runs from a table and checking memory traffic
`timescale 1ns/1ps
`default_nettype none

module tb_sparse_streamer import streamer_pkg::*; ();

  typedef struct packed {
    logic [15:0] meta_base;
    logic [15:0] x_base;
    logic [7:0]  x_len;
    logic [15:0] y_base;
    logic [7:0]  y_len;
    logic [15:0] z_base;
    logic [7:0]  n_z;
    logic [7:0]  pat;
  } row_t;

  localparam int NUM_RUNS = 3;
  localparam int NCH      = 2;
  localparam int LIMIT    = 4000;

  // meta_base, x_base, x_len, y_base, y_len, z_base, Z items, ready pattern
  localparam row_t ROWS [NUM_RUNS] = '{
    '{16'h0010, 16'h1000, 8'd2, 16'h3000, 8'd1, 16'hf000, 8'd8,  8'hff},
    '{16'h0040, 16'h2000, 8'd3, 16'h5000, 8'd2, 16'hf100, 8'd6,  8'hb5},
    '{16'h0080, 16'h0100, 8'd1, 16'h7000, 8'd4, 16'hf200, 8'd10, 8'h5a}
  };

  logic                clk_i;
  logic                rst_ni;
  logic                clear_i;
  run_ctrl_t           run_ctrl;
  run_params_t         run_params;
  logic                x_valid, y_valid, x_ready, y_ready;
  logic [DW-1:0]       x_data, y_data;
  logic                z_valid, z_ready;
  logic [Z_ITEM_W-1:0] z_data;
  mem_req_t            mem_req;
  mem_rsp_t            mem_rsp;
  logic [META_W-1:0]   metadata;
  integer              seed;
  int                  wr_cnt;
  logic [15:0]         z_items [$];

  sparse_streamer uut (
    .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear_i),
    .run_ctrl_i (run_ctrl), .run_params_i (run_params),
    .x_valid_o (x_valid), .x_data_o (x_data), .x_ready_i (x_ready),
    .y_valid_o (y_valid), .y_data_o (y_data), .y_ready_i (y_ready),
    .z_valid_i (z_valid), .z_data_i (z_data), .z_ready_o (z_ready),
    .mem_req_o (mem_req), .mem_rsp_i (mem_rsp), .metadata_o (metadata)
  );

  mem_model u_mem (
    .clk_i (clk_i), .rst_ni (rst_ni), .mem_req_i (mem_req), .mem_rsp_o (mem_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Granted writes, used to tell when the store has drained
  always @(posedge clk_i) begin
    if (mem_req.req && mem_req.we && mem_rsp.gnt) begin
      wr_cnt++;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("Errors found");
    $fatal(1);
  endtask

  // Address of word idx of an operand stream, from the block rule
  function automatic logic [15:0] block_addr(input logic [15:0] mb, input logic [15:0] base,
                                             input logic [7:0] len, input int idx);
    int          fg;
    logic [31:0] chunk;
    logic [7:0]  f;
    fg    = idx / int'(len);
    chunk = u_mem.mem_q[16'(int'(mb) + fg / FIELDS_PER_CHUNK)];
    f     = chunk[FIELD_W*(fg % FIELDS_PER_CHUNK) +: FIELD_W];
    return base + 16'(f) * 16'(len) + 16'(idx % int'(len));
  endfunction

  task automatic check_idle();
    check("x_valid_o", 32'(x_valid), 32'd0);
    check("y_valid_o", 32'(y_valid), 32'd0);
    check("mem_req_o.req", 32'(mem_req.req), 32'd0);
    check("metadata_o", metadata, 32'd0);
    check("z_ready_o", 32'(z_ready), 32'd1);
  endtask

  task automatic run_one(input row_t r);
    int          x_got, y_got, x_total, y_total, cyc, guard, zi, wr_goal;
    logic [15:0] a;
    x_got   = 0;
    y_got   = 0;
    cyc     = 0;
    x_total = NCH * FIELDS_PER_CHUNK * int'(r.x_len);
    y_total = NCH * FIELDS_PER_CHUNK * int'(r.y_len);
    z_items.delete();
    @(negedge clk_i);
    run_params = '{r.meta_base, '{r.x_base, r.x_len}, '{r.y_base, r.y_len}, r.z_base};
    run_ctrl.working = 1'b1;
    @(negedge clk_i);
    run_ctrl.working = 1'b0;
    guard = 0;
    while (x_got < x_total || y_got < y_total) begin
      x_ready = r.pat[cyc % 8] && (x_got < x_total);
      y_ready = r.pat[(cyc + 3) % 8] && (y_got < y_total);
      #1;
      if (x_valid && x_ready) begin
        a = block_addr(r.meta_base, r.x_base, r.x_len, x_got);
        check("x_data_o", x_data, u_mem.mem_q[a]);
        check("metadata_o", metadata,
              u_mem.mem_q[16'(int'(r.meta_base) + x_got / int'(r.x_len) / FIELDS_PER_CHUNK)]);
        x_got++;
      end
      if (y_valid && y_ready) begin
        a = block_addr(r.meta_base, r.y_base, r.y_len, y_got);
        check("y_data_o", y_data, u_mem.mem_q[a]);
        check("metadata_o", metadata,
              u_mem.mem_q[16'(int'(r.meta_base) + y_got / int'(r.y_len) / FIELDS_PER_CHUNK)]);
        y_got++;
      end
      cyc++;
      guard++;
      if (guard > LIMIT) timeout("X and Y stream words");
      @(negedge clk_i);
    end
    x_ready = 1'b0;
    y_ready = 1'b0;
    // Both operands used up, so the next chunk is fetched
    guard = 0;
    while (metadata !== u_mem.mem_q[16'(int'(r.meta_base) + NCH)]) begin
      guard++;
      if (guard > LIMIT) timeout("the chunk after the last used one");
      @(negedge clk_i);
    end
    wr_goal = wr_cnt + int'(r.n_z) / 2;
    zi      = 0;
    guard   = 0;
    while (zi < int'(r.n_z)) begin
      z_valid = 1'b1;
      z_data  = 16'($random(seed));
      #1;
      while (!z_ready) begin
        guard++;
        if (guard > LIMIT) timeout("z_ready_o");
        @(negedge clk_i);
        #1;
      end
      z_items.push_back(z_data);
      zi++;
      @(negedge clk_i);
    end
    z_valid = 1'b0;
    guard = 0;
    while (wr_cnt < wr_goal) begin
      guard++;
      if (guard > LIMIT) timeout("Z word writes");
      @(negedge clk_i);
    end
    run_ctrl.done = 1'b1;
    guard = 0;
    do begin
      @(negedge clk_i);
      guard++;
      if (guard > LIMIT) timeout("both FSMs to become inactive");
    end while (int'(uut.u_load.state_q) != 0 || int'(uut.u_store.state_q) != 0);
    run_ctrl.done = 1'b0;
    for (int m = 0; m < int'(r.n_z) / 2; m++) begin
      check("z word in memory", u_mem.mem_q[r.z_base + 16'(m)],
            {z_items[2*m+1], z_items[2*m]});
    end
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    #1;
    check_idle();
  endtask

  initial begin
    seed       = 32'hc3432291;
    wr_cnt     = 0;
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    run_ctrl   = '0;
    run_params = '0;
    x_ready    = 1'b0;
    y_ready    = 1'b0;
    z_valid    = 1'b0;
    z_data     = '0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_idle();
    for (int i = 0; i < NUM_RUNS; i++) begin
      run_one(ROWS[i]);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
verilog/streamer_pkg.sv
verilog/mem_port_arbiter.sv
verilog/burst_source.sv
verilog/block_scheduler.sv
verilog/load_controller.sv
verilog/z_packer.sv
verilog/z_store_engine.sv
verilog/sparse_streamer.sv
tests/mem_model.sv
tests/tb_sparse_streamer.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status carries pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_sparse_streamer \
  -f compile.f -o tb_sparse_streamer \
  && ./obj_dir/tb_sparse_streamer \
  || exit 1
